// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := sportTb
FILELIST := build.f
OBJDIR   := obj_dir
PASSMSG  := Test passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// File: build.f
logic/sportPkg.sv
logic/sportCtlRegs.sv
logic/sportClkGen.sv
logic/sportTx.sv
logic/sportRx.sv
logic/sportTop.sv
testbench/sportTop_chk.sv
testbench/sportTb.sv

// File: logic/sportClkGen.sv
`default_nettype none

module sportClkGen (
  input  wire                    DSPCLK,
  input  wire                    RST,
  input  wire sportPkg::dataWord sclkdiv,
  input  wire sportPkg::dataWord fsdiv,
  output logic                   bitTick,
  output logic                   frameTick,
  output logic                   sclk
);

  sportPkg::dataWord bitCnt;
  sportPkg::dataWord frameCnt;
  logic              bitEnd;

  assign bitEnd = (bitCnt == '0);

  // One bit period is SCLKDIV+1 clocks.
  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      bitCnt  <= '0;
      bitTick <= 1'b0;
    end
    else if (bitEnd)
    begin
      bitCnt  <= sclkdiv;
      bitTick <= 1'b1;
    end
    else
    begin
      bitCnt  <= bitCnt - 1'b1;
      bitTick <= 1'b0;
    end
  end

  // The frame counter steps on the same edge that raises bitTick, so frameTick lines up with it.
  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      frameCnt  <= '0;
      frameTick <= 1'b0;
    end
    else if (bitEnd)
    begin
      if (frameCnt == '0)
      begin
        frameCnt  <= fsdiv;
        frameTick <= 1'b1;
      end
      else
      begin
        frameCnt  <= frameCnt - 1'b1;
        frameTick <= 1'b0;
      end
    end
    else
    begin
      frameTick <= 1'b0;
    end
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      sclk <= 1'b0;
    end
    else if (bitTick)
    begin
      sclk <= ~sclk;
    end
  end

endmodule

`default_nettype wire

// File: logic/sportCtlRegs.sv
`default_nettype none

module sportCtlRegs (
  input  wire                    DSPCLK,
  input  wire                    RST,
  input  wire sportPkg::dataWord dmd,
  input  wire                    autoWe,
  input  wire                    fsdivWe,
  input  wire                    sclkdivWe,
  input  wire                    sctlWe,
  input  wire                    mwordWe,
  input  wire                    selAuto,
  input  wire                    selFsdiv,
  input  wire                    selSclkdiv,
  input  wire                    selSctl,
  input  wire                    selMword,
  input  wire sportPkg::dataWord rxWord,
  input  wire                    selRx,
  output sportPkg::dataWord      dmdOut,
  output sportPkg::autoFields    auto,
  output sportPkg::sctlFields    sctl,
  output sportPkg::slenField     slen,
  output sportPkg::dataWord      fsdiv,
  output sportPkg::dataWord      sclkdiv
);

  logic                ac97Set;
  sportPkg::dataWord   mwordReg;
  sportPkg::autoFields autoRead;

  // An MWORD write with bit 14 set loads the AC'97 presets.
  assign ac97Set = mwordWe && dmd[14];

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      auto <= '0;
    end
    else if (autoWe)
    begin
      auto <= sportPkg::autoFields'(dmd);
    end
    else
    begin
      // PDFORCE drops again on the cycle after it was written.
      auto.pdForce <= 1'b0;
    end
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      fsdiv <= '0;
    end
    else if (fsdivWe || ac97Set)
    begin
      fsdiv <= ac97Set ? sportPkg::ac97Fsdiv : dmd;
    end
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      sclkdiv <= '0;
    end
    else if (sclkdivWe)
    begin
      sclkdiv <= dmd;
    end
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      sctl <= '0;
    end
    else if (sctlWe || ac97Set)
    begin
      sctl <= sportPkg::sctlFields'(ac97Set ? sportPkg::ac97Sctl : dmd);
    end
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      mwordReg <= '0;
    end
    else if (mwordWe)
    begin
      if (ac97Set)
      begin
        // The preset keeps the written bit 13.
        mwordReg <= (sportPkg::ac97Mword | {2'b00, dmd[13], 13'b0}) & sportPkg::mwordMask;
      end
      else
      begin
        mwordReg <= dmd & sportPkg::mwordMask;
      end
    end
  end

  // The extension bit in MWORD allows words longer than 16 bits.
  assign slen = {mwordReg[15], sctl.slenLow};

  always_comb
  begin
    autoRead = auto;
    autoRead.pdForce = 1'b0;
  end

  assign dmdOut = ({sportPkg::wordWidth{selAuto}} & sportPkg::dataWord'(autoRead))
                | ({sportPkg::wordWidth{selFsdiv}} & fsdiv)
                | ({sportPkg::wordWidth{selSclkdiv}} & sclkdiv)
                | ({sportPkg::wordWidth{selSctl}} & sportPkg::dataWord'(sctl))
                | ({sportPkg::wordWidth{selMword}} & mwordReg)
                | ({sportPkg::wordWidth{selRx}} & rxWord);

endmodule

`default_nettype wire

// File: logic/sportPkg.sv
`default_nettype none

package sportPkg;

  localparam int wordWidth = 16;
  localparam int slenWidth = 5;

  typedef logic [wordWidth-1:0] dataWord;

  // Serial word length minus one.
  typedef logic [slenWidth-1:0] slenField;

  typedef struct packed {
    logic       loop;
    logic       iSclk;
    logic       invXsclk;
    logic [1:0] fsd;
    logic       fsw;
    logic       itfs;
    logic       irfs;
    logic       invTfs;
    logic       invRfs;
    logic [1:0] dtype;
    logic [3:0] slenLow;
  } sctlFields;

  typedef struct packed {
    logic       xtalDis;
    logic       xtalDelay;
    logic       pdForce;
    logic       pucr;
    logic [2:0] tiReg;
    logic [1:0] tmReg;
    logic [2:0] riReg;
    logic [1:0] rmReg;
    logic       tBuf;
    logic       rBuf;
  } autoFields;

  // MWORD keeps bits 15:13 and 7:0 only.
  localparam dataWord mwordMask = 16'hE0FF;

  localparam dataWord ac97Fsdiv = 16'h00FF;
  localparam dataWord ac97Sctl  = 16'h4A0F;
  localparam dataWord ac97Mword = 16'h4001;

  typedef enum logic [1:0] {
    idle,
    waitFrame,
    shift
  } txState;

endpackage

`default_nettype wire

// File: logic/sportRx.sv
`default_nettype none

module sportRx (
  input  wire                     DSPCLK,
  input  wire                     RST,
  input  wire sportPkg::slenField slen,
  input  wire                     bitTick,
  input  wire                     dr,
  input  wire                     rfs,
  output sportPkg::dataWord       rxWord,
  output logic                    rxDone
);

  sportPkg::dataWord  shiftReg;
  sportPkg::dataWord  nextWord;
  sportPkg::slenField bitCnt;
  logic               active;
  logic               first;
  logic               last;
  logic               wordStored;

  // The first bit is sampled at the same tick that sees frame sync.
  assign first = bitTick && !active && rfs;
  assign last  = (first && (slen == '0)) || (bitTick && active && (bitCnt == '0));

  // Starting from zero keeps the upper bits clear for short words.
  assign nextWord = first ? {{(sportPkg::wordWidth - 1){1'b0}}, dr} : {shiftReg[14:0], dr};

  always_ff @(posedge DSPCLK)
  begin
    if (first || (bitTick && active))
    begin
      shiftReg <= nextWord;
    end
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      active     <= 1'b0;
      bitCnt     <= '0;
      rxWord     <= '0;
      wordStored <= 1'b0;
      rxDone     <= 1'b0;
    end
    else
    begin
      wordStored <= last;
      rxDone     <= wordStored;
      if (last)
      begin
        active <= 1'b0;
        rxWord <= nextWord;
      end
      else if (first)
      begin
        active <= 1'b1;
        bitCnt <= slen - 1'b1;
      end
      else if (bitTick && active)
      begin
        bitCnt <= bitCnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/sportTop.sv
`default_nettype none

module sportTop (
  input  wire                    DSPCLK,
  input  wire                    RST,
  input  wire sportPkg::dataWord dmd,
  input  wire                    autoWe,
  input  wire                    fsdivWe,
  input  wire                    sclkdivWe,
  input  wire                    sctlWe,
  input  wire                    mwordWe,
  input  wire                    txWe,
  input  wire                    selAuto,
  input  wire                    selFsdiv,
  input  wire                    selSclkdiv,
  input  wire                    selSctl,
  input  wire                    selMword,
  input  wire                    selRx,
  output sportPkg::dataWord      dmdOut,
  input  wire                    dr,
  input  wire                    rfs,
  output logic                   dt,
  output logic                   tfs,
  output logic                   sclk,
  output logic                   txDone,
  output logic                   rxDone,
  output logic                   xtalDis,
  output logic                   xtalDelay,
  output logic                   pdForce,
  output logic                   pucr
);

  sportPkg::autoFields auto;
  sportPkg::sctlFields sctl;
  sportPkg::slenField  slen;
  sportPkg::dataWord   fsdiv;
  sportPkg::dataWord   sclkdiv;
  sportPkg::dataWord   rxWord;
  logic                bitTick;
  logic                frameTick;
  logic                rxData;
  logic                rxFrame;

  sportCtlRegs i_regs (
    .DSPCLK(DSPCLK), .RST(RST), .dmd(dmd),
    .autoWe(autoWe), .fsdivWe(fsdivWe), .sclkdivWe(sclkdivWe),
    .sctlWe(sctlWe), .mwordWe(mwordWe),
    .selAuto(selAuto), .selFsdiv(selFsdiv), .selSclkdiv(selSclkdiv),
    .selSctl(selSctl), .selMword(selMword), .rxWord(rxWord), .selRx(selRx),
    .dmdOut(dmdOut), .auto(auto), .sctl(sctl), .slen(slen),
    .fsdiv(fsdiv), .sclkdiv(sclkdiv)
  );

  sportClkGen i_clkGen (
    .DSPCLK(DSPCLK), .RST(RST), .sclkdiv(sclkdiv), .fsdiv(fsdiv),
    .bitTick(bitTick), .frameTick(frameTick), .sclk(sclk)
  );

  sportTx i_tx (
    .DSPCLK(DSPCLK), .RST(RST), .dmd(dmd), .txWe(txWe), .sctl(sctl), .slen(slen),
    .bitTick(bitTick), .frameTick(frameTick), .dt(dt), .tfs(tfs), .txDone(txDone)
  );

  // Loopback feeds the transmit pins straight into the receiver.
  assign rxData  = sctl.loop ? dt : dr;
  assign rxFrame = sctl.loop ? tfs : rfs;

  sportRx i_rx (
    .DSPCLK(DSPCLK), .RST(RST), .slen(slen), .bitTick(bitTick),
    .dr(rxData), .rfs(rxFrame), .rxWord(rxWord), .rxDone(rxDone)
  );

  assign xtalDis   = auto.xtalDis;
  assign xtalDelay = auto.xtalDelay;
  assign pdForce   = auto.pdForce;
  assign pucr      = auto.pucr;

endmodule

`default_nettype wire

// File: logic/sportTx.sv
`default_nettype none

module sportTx (
  input  wire                     DSPCLK,
  input  wire                     RST,
  input  wire sportPkg::dataWord  dmd,
  input  wire                     txWe,
  input  wire sportPkg::sctlFields sctl,
  input  wire sportPkg::slenField slen,
  input  wire                     bitTick,
  input  wire                     frameTick,
  output logic                    dt,
  output logic                    tfs,
  output logic                    txDone
);

  sportPkg::txState   state;
  sportPkg::dataWord  holdReg;
  sportPkg::dataWord  shiftReg;
  sportPkg::slenField bitCnt;
  logic               pending;
  logic               start;

  // With ITFS set a word only leaves on a frame tick.
  assign start = (state == sportPkg::waitFrame) && bitTick && (!sctl.itfs || frameTick);

  always_ff @(posedge DSPCLK)
  begin
    if (txWe)
    begin
      holdReg <= dmd;
    end
    if (start)
    begin
      // Left-align the word so that its top bit sits at bit 15.
      shiftReg <= slen[4] ? holdReg : holdReg << (4'd15 - slen[3:0]);
    end
    else if ((state == sportPkg::shift) && bitTick && !bitCnt[4])
    begin
      shiftReg <= {shiftReg[14:0], 1'b0};
    end
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      state   <= sportPkg::idle;
      pending <= 1'b0;
      bitCnt  <= '0;
      dt      <= 1'b0;
      tfs     <= 1'b0;
      txDone  <= 1'b0;
    end
    else
    begin
      txDone <= 1'b0;
      if (txWe)
      begin
        pending <= 1'b1;
      end
      else if (start)
      begin
        pending <= 1'b0;
      end
      case (state)
        sportPkg::idle:
        begin
          if (pending)
          begin
            state <= sportPkg::waitFrame;
          end
        end
        sportPkg::waitFrame:
        begin
          if (start)
          begin
            state  <= sportPkg::shift;
            bitCnt <= slen;
            tfs    <= 1'b1;
            dt     <= !slen[4] && holdReg[slen[3:0]];
          end
        end
        sportPkg::shift:
        begin
          if (bitTick)
          begin
            tfs <= 1'b0;
            if (bitCnt == '0)
            begin
              dt     <= 1'b0;
              txDone <= 1'b1;
              state  <= sportPkg::idle;
            end
            else
            begin
              bitCnt <= bitCnt - 1'b1;
              // Bits above 15 of a long word go out as zeros.
              dt <= bitCnt[4] ? (bitCnt == 5'd16) && shiftReg[15] : shiftReg[14];
            end
          end
        end
        default:
        begin
          state <= sportPkg::idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: testbench/sportTb.sv
`default_nettype none

module sportTb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef enum int {regAuto, regFsdiv, regSclkdiv, regSctl, regMword, regRx} regId;

  logic              DSPCLK;
  logic              RST;
  sportPkg::dataWord dmd;
  sportPkg::dataWord dmdOut;
  logic              autoWe, fsdivWe, sclkdivWe, sctlWe, mwordWe, txWe;
  logic              selAuto, selFsdiv, selSclkdiv, selSctl, selMword, selRx;
  logic              dr, rfs, dt, tfs, sclk, txDone, rxDone;
  logic              xtalDis, xtalDelay, pdForce, pucr;

  sportPkg::dataWord expRegs [6];
  sportPkg::dataWord value;
  int                readErrors;
  int                timeouts;
  int                assertFails;
  int                k;

  sportTop i_dut (.*);

  always #2 DSPCLK = ~DSPCLK;

  // Expected readback after a register write.
  function automatic void modelWrite(input regId id, input sportPkg::dataWord word);
    case (id)
      regAuto: expRegs[regAuto] = word & ~16'h2000;
      regMword:
      begin
        if (word[14])
        begin
          expRegs[regFsdiv] = sportPkg::ac97Fsdiv;
          expRegs[regSctl]  = sportPkg::ac97Sctl;
          expRegs[regMword] = (sportPkg::ac97Mword | (word & 16'h2000)) & ~16'h1F00;
        end
        else
        begin
          expRegs[regMword] = word & ~16'h1F00;
        end
      end
      default: expRegs[id] = word;
    endcase
  endfunction

  task automatic applyReset();
    RST = 1'b1;
    repeat (5) @(posedge DSPCLK);
    if ({tfs, dt, txDone, rxDone, sclk} !== 5'b0)
    begin
      readErrors++;
      $display("** Error at %0t: serial outputs are not low in reset", $time);
    end
    #1;
    RST = 1'b0;
    foreach (expRegs[i])
    begin
      expRegs[i] = '0;
    end
  endtask

  task automatic writeReg(input regId id, input sportPkg::dataWord word);
    @(posedge DSPCLK);
    #1;
    dmd       = word;
    autoWe    = (id == regAuto);
    fsdivWe   = (id == regFsdiv);
    sclkdivWe = (id == regSclkdiv);
    sctlWe    = (id == regSctl);
    mwordWe   = (id == regMword);
    modelWrite(id, word);
    @(posedge DSPCLK);
    #1;
    {autoWe, fsdivWe, sclkdivWe, sctlWe, mwordWe} = 5'b0;
  endtask

  task automatic checkReg(input regId id, input sportPkg::dataWord expected);
    selAuto    = (id == regAuto);
    selFsdiv   = (id == regFsdiv);
    selSclkdiv = (id == regSclkdiv);
    selSctl    = (id == regSctl);
    selMword   = (id == regMword);
    selRx      = (id == regRx);
    @(negedge DSPCLK);
    if (dmdOut !== expected)
    begin
      readErrors++;
      $display("** Error at %0t: %s read %h, expected %h", $time, id.name(), dmdOut, expected);
    end
    @(posedge DSPCLK);
    #1;
    {selAuto, selFsdiv, selSclkdiv, selSctl, selMword, selRx} = 6'b0;
  endtask

  task automatic waitDone(input logic forRx, input int limit);
    int n;
    n = 0;
    do
    begin
      @(negedge DSPCLK);
      n++;
    end
    while (((forRx ? rxDone : txDone) !== 1'b1) && (n < limit));
    if ((forRx ? rxDone : txDone) !== 1'b1)
    begin
      timeouts++;
      $display("Timed out waiting for %s", forRx ? "rxDone" : "txDone");
    end
  endtask

  task automatic waitToggles(input int count, input int limit);
    int   n;
    logic last;
    repeat (count)
    begin
      last = sclk;
      n    = 0;
      while ((sclk === last) && (n < limit))
      begin
        @(negedge DSPCLK);
        n++;
      end
      if (sclk === last)
      begin
        timeouts++;
        $display("Timed out waiting for sclk to toggle");
      end
    end
  endtask

  // Sends one random word through the loopback path and reads it back from RX.
  task automatic loopWord(input logic itfs);
    sportPkg::sctlFields ctl;
    sportPkg::dataWord   data;
    sportPkg::dataWord   mask;
    int                  slenVal;
    slenVal     = $urandom % 16;
    data        = sportPkg::dataWord'($urandom);
    mask        = sportPkg::dataWord'((32'd1 << (slenVal + 1)) - 32'd1);
    ctl         = '0;
    ctl.loop    = 1'b1;
    ctl.itfs    = itfs;
    ctl.slenLow = slenVal[3:0];
    writeReg(regSctl, sportPkg::dataWord'(ctl));
    dmd  = data;
    txWe = 1'b1;
    @(posedge DSPCLK);
    #1;
    txWe = 1'b0;
    waitDone(1'b0, 2000);
    waitDone(1'b1, 200);
    @(posedge DSPCLK);
    #1;
    checkReg(regRx, data & mask);
  endtask

  initial
  begin
    void'($urandom(32'h2df0));
    DSPCLK = 1'b0;
    RST    = 1'b1;
    dmd    = '0;
    dr     = 1'b0;
    rfs    = 1'b0;
    {autoWe, fsdivWe, sclkdivWe, sctlWe, mwordWe, txWe} = 6'b0;
    {selAuto, selFsdiv, selSclkdiv, selSctl, selMword, selRx} = 6'b0;
    readErrors = 0;
    timeouts   = 0;
    applyReset();
    for (k = 0; k < 6; k++)
    begin
      checkReg(regId'(k), '0);
    end
    for (k = 0; k < 20; k++)
    begin
      value = sportPkg::dataWord'($urandom);
      if ((k % 5) == 4)
      begin
        value[14] = 1'b0;
      end
      writeReg(regId'(k % 5), value);
      checkReg(regId'(k % 5), expRegs[k % 5]);
    end
    // AC'97 preset, once with DMD bit 13 clear and once with it set.
    for (k = 0; k < 2; k++)
    begin
      value     = sportPkg::dataWord'($urandom);
      value[14] = 1'b1;
      value[13] = k[0];
      writeReg(regMword, value);
      checkReg(regFsdiv, expRegs[regFsdiv]);
      checkReg(regSctl, expRegs[regSctl]);
      checkReg(regMword, expRegs[regMword]);
    end
    value     = sportPkg::dataWord'($urandom);
    value[13] = 1'b1;
    writeReg(regAuto, value);
    checkReg(regAuto, expRegs[regAuto]);
    // Large random dividers would stall the counters, so start the serial part clean.
    applyReset();
    writeReg(regSclkdiv, 16'd3);
    checkReg(regSclkdiv, expRegs[regSclkdiv]);
    writeReg(regFsdiv, 16'd3);
    checkReg(regFsdiv, expRegs[regFsdiv]);
    waitToggles(8, 100);
    for (k = 0; k < 8; k++)
    begin
      loopWord(k[0]);
    end
    assertFails = i_dut.i_chk.fails;
    $display("Readback errors %0d, timeouts %0d, assertion failures %0d",
             readErrors, timeouts, assertFails);
    if ((readErrors + timeouts + assertFails) == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/sportTop_chk.sv
`default_nettype none

module sportTop_chk (
  input wire                      DSPCLK,
  input wire                      RST,
  input wire sportPkg::dataWord   dmd,
  input wire                      autoWe,
  input wire                      sclkdivWe,
  input wire                      sctlWe,
  input wire                      mwordWe,
  input wire sportPkg::dataWord   sclkdiv,
  input wire sportPkg::dataWord   fsdiv,
  input wire sportPkg::sctlFields sctl,
  input wire                      pdForce,
  input wire                      xtalDis,
  input wire                      xtalDelay,
  input wire                      pucr,
  input wire                      sclk,
  input wire                      txDone,
  input wire                      rxDone
);

  timeunit 1ns;
  timeprecision 100ps;

  int          fails = 0;
  logic        ac97Set;
  logic        sclkPrev;
  logic [16:0] gap;
  logic [1:0]  quiet;

  assign ac97Set = mwordWe && dmd[14];

  // Gap counts clocks since the last sclk edge. Quiet counts sclk edges since
  // the last SCLKDIV write, because up to three edges after a write can still
  // follow the old divider.
  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      sclkPrev <= 1'b0;
      gap      <= '0;
      quiet    <= '0;
    end
    else
    begin
      sclkPrev <= sclk;
      gap      <= (sclk != sclkPrev) ? 17'd1 : gap + 17'd1;
      if (sclkdivWe)
      begin
        quiet <= '0;
      end
      else if ((sclk != sclkPrev) && (quiet != 2'd3))
      begin
        quiet <= quiet + 2'd1;
      end
    end
  end

  sclkdivWrite: assert property (@(posedge DSPCLK) disable iff (RST)
    sclkdivWe |=> (sclkdiv == $past(dmd)))
    else
    begin
      $error("SCLKDIV did not take the written word");
      fails++;
    end

  sctlWrite: assert property (@(posedge DSPCLK) disable iff (RST)
    (sctlWe && !ac97Set) |=> (sportPkg::dataWord'(sctl) == $past(dmd)))
    else
    begin
      $error("SCTL did not take the written word");
      fails++;
    end

  presetLoad: assert property (@(posedge DSPCLK) disable iff (RST)
    ac97Set |=> (fsdiv == sportPkg::ac97Fsdiv)
                && (sportPkg::dataWord'(sctl) == sportPkg::ac97Sctl))
    else
    begin
      $error("AC'97 preset was not loaded into FSDIV and SCTL");
      fails++;
    end

  pdForceSet: assert property (@(posedge DSPCLK) disable iff (RST)
    (autoWe && dmd[13]) |=> pdForce)
    else
    begin
      $error("PDFORCE did not rise after the AUTO write");
      fails++;
    end

  pdForceClear: assert property (@(posedge DSPCLK) disable iff (RST)
    (pdForce && !autoWe) |=> !pdForce)
    else
    begin
      $error("PDFORCE stayed high for more than one cycle");
      fails++;
    end

  // XTALDIS, XTALDELAY and PUCR sit at AUTO bits 15, 14 and 12.
  powerBits: assert property (@(posedge DSPCLK) disable iff (RST)
    autoWe |=> ({xtalDis, xtalDelay, pucr} == $past({dmd[15], dmd[14], dmd[12]})))
    else
    begin
      $error("Power outputs do not follow the written AUTO word");
      fails++;
    end

  sclkPeriod: assert property (@(posedge DSPCLK) disable iff (RST)
    ((sclk != sclkPrev) && (quiet == 2'd3)) |-> (gap == ({1'b0, sclkdiv} + 17'd1)))
    else
    begin
      $error("sclk half period does not match SCLKDIV+1");
      fails++;
    end

  txDonePulse: assert property (@(posedge DSPCLK) disable iff (RST)
    txDone |=> !txDone)
    else
    begin
      $error("txDone was high for more than one cycle");
      fails++;
    end

  rxDonePulse: assert property (@(posedge DSPCLK) disable iff (RST)
    rxDone |=> !rxDone)
    else
    begin
      $error("rxDone was high for more than one cycle");
      fails++;
    end

endmodule

bind sportTop sportTop_chk i_chk (.*);

`default_nettype wire
